// ==== rtl/rob_pkg.sv ====
package rob_pkg;

    // buffer depth and the tag that indexes it
    localparam int rob_depth = 8;
    localparam int tag_width = 3;

    // occupancy must hold the value rob_depth itself
    localparam int count_width = tag_width + 1;

    typedef logic [tag_width-1:0]   tag_t;
    typedef logic [count_width-1:0] count_t;
    typedef logic [4:0]             reg_t;

    typedef enum logic [1:0] {
        ALU,
        LD,
        ST,
        BR
    } op_t;

    // four-phase handshake machine shared by both channel ports
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DROP
    } hs_state_t;

    // decoded instruction as it arrives from dispatch
    // for ST, rd names the store data source
    typedef struct packed {
        op_t  op;
        reg_t rd;
        reg_t src;
    } dispatch_t;

    // completion report from an execution unit
    typedef struct packed {
        tag_t tag;
        logic mispredict;
    } complete_t;

    // retiring instruction as seen by the regfile and data memory
    typedef struct packed {
        tag_t tag;
        op_t  op;
        reg_t rd;
        logic reg_write;
        logic mem_write;
        logic flush;
    } commit_t;

endpackage

// ==== rtl/dispatch_port.sv ====
module dispatch_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_req,
    input  rob_pkg::dispatch_t disp,
    output logic               disp_ack,
    output rob_pkg::tag_t      disp_tag,
    input  logic               rob_full,
    input  logic               flush_pending,
    output logic               alloc_valid,
    output rob_pkg::dispatch_t alloc,
    input  rob_pkg::tag_t      alloc_tag
);
    import rob_pkg::*;

    hs_state_t state_q;
    hs_state_t state_d;
    logic      can_alloc;

    // room left and no flush about to retire
    assign can_alloc = disp_req && !rob_full && !flush_pending;

    // exactly one allocation per request, never while the ack is up
    assign alloc_valid = can_alloc && (state_q != WAIT_DROP);
    assign alloc       = disp;
    assign disp_ack    = (state_q == WAIT_DROP);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (can_alloc) begin
                    state_d = WAIT_DROP;
                end else if (disp_req) begin
                    // buffer full, hold off the ack
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (can_alloc) begin
                    state_d = WAIT_DROP;
                end else if (!disp_req) begin
                    state_d = IDLE;
                end
            end
            WAIT_DROP: begin
                if (!disp_req) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // tag stays put until the producer closes the handshake
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            disp_tag <= alloc_tag;
        end
    end

endmodule

// ==== rtl/rob.sv ====
module rob (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  rob_pkg::dispatch_t alloc,
    output rob_pkg::tag_t      alloc_tag,
    input  logic               cmpl_valid,
    input  rob_pkg::complete_t cmpl,
    output logic               head_valid,
    output rob_pkg::commit_t   head,
    input  logic               retire,
    output logic               rob_full,
    output logic               rob_empty,
    output logic               flush_pending
);
    import rob_pkg::*;

    // per-entry payload, written at allocation
    dispatch_t              entry_q [rob_depth];
    logic [rob_depth-1:0]   busy_q;
    logic [rob_depth-1:0]   done_q;
    logic [rob_depth-1:0]   mispredict_q;

    tag_t                   head_q;
    tag_t                   tail_q;
    count_t                 count_q;

    logic                   alloc_fire;
    logic                   head_flush;
    dispatch_t              head_entry;

    assign alloc_tag  = tail_q;
    assign rob_full   = (count_q == count_t'(rob_depth));
    assign rob_empty  = (count_q == '0);
    assign alloc_fire = alloc_valid && !rob_full;

    assign head_entry = entry_q[head_q];
    assign head_valid = busy_q[head_q] && done_q[head_q];

    // a resolved, mispredicted branch at the head
    assign head_flush    = (head_entry.op == BR) && mispredict_q[head_q];
    assign flush_pending = head_valid && head_flush;

    always_comb begin
        head.tag       = head_q;
        head.op        = head_entry.op;
        head.rd        = head_entry.rd;
        head.reg_write = (head_entry.op == ALU) || (head_entry.op == LD);
        head.mem_write = (head_entry.op == ST);
        head.flush     = head_flush;
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entry_q[tail_q] <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q       <= '0;
            done_q       <= '0;
            mispredict_q <= '0;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
        end else begin
            if (alloc_fire) begin
                busy_q[tail_q]       <= 1'b1;
                done_q[tail_q]       <= 1'b0;
                mispredict_q[tail_q] <= 1'b0;
                tail_q               <= tail_q + 1'b1;
            end

            // completions for free entries are dropped
            if (cmpl_valid && busy_q[cmpl.tag]) begin
                done_q[cmpl.tag]       <= 1'b1;
                mispredict_q[cmpl.tag] <= cmpl.mispredict;
            end

            unique case ({alloc_fire, retire})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase

            if (retire) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;

                // drop every younger entry, including one allocated now
                if (head_flush) begin
                    busy_q  <= '0;
                    tail_q  <= head_q + 1'b1;
                    count_q <= '0;
                end
            end
        end
    end

endmodule

// ==== rtl/commit_port.sv ====
module commit_port (
    input  logic             clk,
    input  logic             rst,
    input  logic             head_valid,
    input  rob_pkg::commit_t head,
    output logic             retire,
    output logic             commit_req,
    output rob_pkg::commit_t commit,
    input  logic             commit_ack
);
    import rob_pkg::*;

    hs_state_t state_q;
    hs_state_t state_d;

    assign commit_req = (state_q == WAIT_ACK);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (head_valid) begin
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (commit_ack) begin
                    state_d = WAIT_DROP;
                end
            end
            WAIT_DROP: begin
                // consumer must release ack before the next entry
                if (!commit_ack) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            retire  <= 1'b0;
        end else begin
            state_q <= state_d;
            // one pulse per acknowledged commit
            retire  <= (state_q == WAIT_ACK) && commit_ack;
        end
    end

    // snapshot of the head, held for the whole request
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && head_valid) begin
            commit <= head;
        end
    end

endmodule

// ==== rtl/rob_subsystem.sv ====
module rob_subsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_req,
    input  rob_pkg::dispatch_t disp,
    output logic               disp_ack,
    output rob_pkg::tag_t      disp_tag,
    input  logic               cmpl_valid,
    input  rob_pkg::complete_t cmpl,
    output logic               commit_req,
    output rob_pkg::commit_t   commit,
    input  logic               commit_ack,
    output logic               rob_full,
    output logic               rob_empty
);
    import rob_pkg::*;

    logic      alloc_valid;
    dispatch_t alloc;
    tag_t      alloc_tag;
    logic      head_valid;
    commit_t   head;
    logic      retire;
    logic      flush_pending;

    dispatch_port u_dispatch_port (
        .clk           (clk),
        .rst           (rst),
        .disp_req      (disp_req),
        .disp          (disp),
        .disp_ack      (disp_ack),
        .disp_tag      (disp_tag),
        .rob_full      (rob_full),
        .flush_pending (flush_pending),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .alloc_tag     (alloc_tag)
    );

    rob u_rob (
        .clk           (clk),
        .rst           (rst),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .alloc_tag     (alloc_tag),
        .cmpl_valid    (cmpl_valid),
        .cmpl          (cmpl),
        .head_valid    (head_valid),
        .head          (head),
        .retire        (retire),
        .rob_full      (rob_full),
        .rob_empty     (rob_empty),
        .flush_pending (flush_pending)
    );

    commit_port u_commit_port (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head       (head),
        .retire     (retire),
        .commit_req (commit_req),
        .commit     (commit),
        .commit_ack (commit_ack)
    );

endmodule

// ==== verification/rob_properties.sv ====
module rob_properties (
    input logic             clk,
    input logic             rst,
    input logic             disp_req,
    input logic             disp_ack,
    input logic             commit_req,
    input rob_pkg::commit_t commit,
    input logic             rob_full,
    input logic             rob_empty
);

    // payload frozen while the request is up
    commit_stable: assert property (@(posedge clk) disable iff (rst)
        commit_req && $past(commit_req) |-> $stable(commit))
        else $error("commit changed while commit_req was high");

    disp_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(disp_ack) |-> disp_req)
        else $error("disp_ack rose without disp_req");

    full_empty_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rob_full && rob_empty))
        else $error("rob_full and rob_empty high together");

endmodule

bind rob_subsystem rob_properties u_rob_properties (.*);

// ==== verification/rob_tb.sv ====
module rob_tb;
    import rob_pkg::*;

    localparam int n_rows    = 22;
    localparam int n_batches = 4;

    // stimulus plus the commit kind it should retire with
    typedef struct packed {
        op_t        op;
        reg_t       rd;
        reg_t       src;
        logic       mispredict;
        logic [1:0] batch;
        logic       reg_write;
        logic       mem_write;
        logic       flush;
    } row_t;

    logic      clk;
    logic      rst;
    logic      disp_req;
    dispatch_t disp;
    logic      disp_ack;
    tag_t      disp_tag;
    logic      cmpl_valid;
    complete_t cmpl;
    logic      commit_req;
    commit_t   commit;
    logic      commit_ack;
    logic      rob_full;
    logic      rob_empty;

    row_t      rows [n_rows];
    tag_t      tags [n_rows];
    bit        dispatched [n_rows];
    bit        completed [n_rows];
    int        n_fill;
    int        n_disp;
    int        n_acked;
    tag_t      exp_tag;
    integer    seed = 32'h64f5_cbf1;

    rob_subsystem u_rob_subsystem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_row(input op_t op, input int rd, input int src, input bit mis,
                           input int batch, input bit rw, input bit mw, input bit fl);
        rows[n_fill] = '{op, reg_t'(rd), reg_t'(src), mis, 2'(batch), rw, mw, fl};
        n_fill++;
    endtask

    task automatic dispatch_batch(input int first, input int cnt);
        int r;
        for (r = first; r < first + cnt; r++) begin
            @(posedge clk);
            disp     <= '{op: rows[r].op, rd: rows[r].rd, src: rows[r].src};
            disp_req <= 1'b1;
            @(posedge clk);
            while (!disp_ack) @(posedge clk);
            check("disp_tag", exp_tag, disp_tag);
            if (r - first == rob_depth) begin
                // ninth entry only fits once a commit has freed the head
                check("ninth ack after a commit", 1, n_acked > 0);
            end
            tags[r]       = disp_tag;
            dispatched[r] = 1'b1;
            exp_tag       = exp_tag + 1'b1;
            n_disp++;
            if (n_disp == rob_depth) begin
                check("rob_full", 1, rob_full);
            end
            disp_req <= 1'b0;
            @(posedge clk);
            while (disp_ack) @(posedge clk);
        end
    endtask

    task automatic complete_batch(input int first, input int cnt);
        int left;
        int r;
        left = cnt;
        // start once the batch is in, or once the buffer is full
        wait (n_disp >= ((cnt < rob_depth) ? cnt : rob_depth));
        while (left > 0) begin
            r = first + int'($unsigned($random(seed)) % cnt);
            @(posedge clk);
            if (dispatched[r] && !completed[r]) begin
                cmpl_valid   <= 1'b1;
                cmpl         <= '{tag: tags[r], mispredict: rows[r].mispredict};
                completed[r] = 1'b1;
                left--;
            end else begin
                cmpl_valid <= 1'b0;
            end
        end
        @(posedge clk);
        cmpl_valid <= 1'b0;
    endtask

    task automatic commit_batch(input int first, input int cnt);
        int r;
        int delay;
        r = first;
        while (r < first + cnt) begin
            @(posedge clk);
            while (!commit_req) @(posedge clk);
            check("commit.tag", tags[r], commit.tag);
            check("commit.op", rows[r].op, commit.op);
            check("commit.rd", rows[r].rd, commit.rd);
            check("commit.reg_write", rows[r].reg_write, commit.reg_write);
            check("commit.mem_write", rows[r].mem_write, commit.mem_write);
            check("commit.flush", rows[r].flush, commit.flush);
            delay = int'($unsigned($random(seed)) % 4);
            repeat (delay) @(posedge clk);
            commit_ack <= 1'b1;
            @(posedge clk);
            while (commit_req) @(posedge clk);
            commit_ack <= 1'b0;
            n_acked++;
            // younger rows of this batch are gone, tags restart after the branch
            if (rows[r].flush) begin
                exp_tag = tags[r] + 1'b1;
                r = first + cnt;
            end else begin
                r++;
            end
        end
    endtask

    task automatic run_batch(input int first, input int cnt);
        n_disp  = 0;
        n_acked = 0;
        fork
            dispatch_batch(first, cnt);
            complete_batch(first, cnt);
            commit_batch(first, cnt);
        join
        repeat (4) begin
            @(posedge clk);
            check("rob_empty after drain", 1, rob_empty);
            check("commit_req after drain", 0, commit_req);
        end
    endtask

    initial begin
        int first;
        int cnt;
        int b;
        int i;
        rst        = 1'b1;
        disp_req   = 1'b0;
        disp       = '0;
        cmpl_valid = 1'b0;
        cmpl       = '0;
        commit_ack = 1'b0;
        n_fill     = 0;
        exp_tag    = '0;

        // op, rd, src, mispredict, batch, then reg_write, mem_write, flush
        add_row(ALU, 1, 2, 0, 0, 1, 0, 0);
        add_row(ALU, 3, 1, 0, 0, 1, 0, 0);
        add_row(ALU, 4, 3, 0, 0, 1, 0, 0);
        add_row(LD, 5, 2, 0, 1, 1, 0, 0);
        add_row(ST, 5, 6, 0, 1, 0, 1, 0);
        add_row(ALU, 7, 5, 0, 1, 1, 0, 0);
        add_row(BR, 0, 7, 0, 1, 0, 0, 0);
        add_row(LD, 8, 7, 0, 1, 1, 0, 0);
        add_row(ALU, 9, 1, 0, 2, 1, 0, 0);
        add_row(LD, 10, 9, 0, 2, 1, 0, 0);
        add_row(BR, 0, 10, 1, 2, 0, 0, 1);
        add_row(ALU, 11, 9, 0, 2, 1, 0, 0);
        add_row(ST, 11, 4, 0, 2, 0, 1, 0);
        // eight to fill the buffer and a ninth that must wait
        for (i = 0; i < 9; i++) begin
            add_row((i % 2) ? LD : ALU, 12 + i, i, 0, 3, 1, 0, 0);
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("rob_empty after reset", 1, rob_empty);
        check("rob_full after reset", 0, rob_full);
        check("disp_ack after reset", 0, disp_ack);
        check("commit_req after reset", 0, commit_req);

        first = 0;
        for (b = 0; b < n_batches; b++) begin
            cnt = 0;
            while (first + cnt < n_rows && rows[first + cnt].batch == b) begin
                cnt++;
            end
            run_batch(first, cnt);
            first += cnt;
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (n_rows * 40) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", n_rows * 40);
        $display("TESTS FAILED");
        $fatal(1);
    end

endmodule

// ==== compile.f ====
rtl/rob_pkg.sv
rtl/dispatch_port.sv
rtl/rob.sv
rtl/commit_port.sv
rtl/rob_subsystem.sv
verification/rob_properties.sv
verification/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob_subsystem

sources:
  - rtl/rob_pkg.sv
  - rtl/dispatch_port.sv
  - rtl/rob.sv
  - rtl/commit_port.sv
  - rtl/rob_subsystem.sv
  - target: simulation
    files:
      - verification/rob_properties.sv
      - verification/rob_tb.sv
